// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf $(OBJ_DIR)

// File: bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// architectural state of the reference model
word_t      m_regs [0:NR_REGS-1];
word_t      m_pc;
logic       m_ld_pending;
word_t      m_ld_addr;
logic [2:0] m_ld_f3;
reg_addr_t  m_ld_rd;

function automatic void clear_model();
    for (int i = 0; i < NR_REGS; i++) begin
        m_regs[i] = '0;
    end
    m_pc         = PC_START;
    m_ld_pending = 1'b0;
    m_ld_addr    = '0;
    m_ld_f3      = '0;
    m_ld_rd      = '0;
endfunction

// memory contents seen by loads
function automatic word_t mem_word(input word_t addr);
    return addr ^ 32'h5a5a_c3c3;
endfunction

function automatic void write_reg(input reg_addr_t rd, input word_t value);
    if (rd != '0) begin
        m_regs[rd] = value;
    end
endfunction

function automatic logic is_known(input logic [6:0] op);
    return op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_IMM, OP_REG, OP_LOAD};
endfunction

function automatic word_t alu_op(input logic [2:0] f3, input logic alt,
                                 input word_t a, input word_t b);
    case (f3)
        F3_ADD:  return alt ? a - b : a + b;
        F3_SLL:  return a << b[4:0];
        F3_SLT:  return {31'b0, $signed(a) < $signed(b)};
        F3_SLTU: return {31'b0, a < b};
        F3_XOR:  return a ^ b;
        F3_SR: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        F3_OR:   return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(input logic [2:0] f3, input word_t a, input word_t b);
    case (f3)
        F3_BEQ:  return a == b;
        F3_BNE:  return a != b;
        F3_BLT:  return $signed(a) < $signed(b);
        F3_BGE:  return $signed(a) >= $signed(b);
        F3_BLTU: return a < b;
        default: return a >= b;
    endcase
endfunction

// halfword lane picked by address bit 1
function automatic word_t load_result(input logic [2:0] f3, input word_t addr);
    word_t       data;
    logic [7:0]  b8;
    logic [15:0] h16;
    data = mem_word(addr);
    b8   = data[{addr[1:0], 3'b000} +: 8];
    h16  = addr[1] ? data[31:16] : data[15:0];
    case (f3)
        F3_LB:   return {{24{b8[7]}}, b8};
        F3_LH:   return {{16{h16[15]}}, h16};
        F3_LBU:  return {24'b0, b8};
        F3_LHU:  return {16'b0, h16};
        default: return data;
    endcase
endfunction

// random instruction from the kept set, executed on the model right away
task automatic next_instruction(output word_t instr);
    word_t      r;
    word_t      rs1v;
    word_t      rs2v;
    word_t      imm;
    word_t      next;
    logic [3:0] kind;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic [2:0] f3;
    logic [6:0] f7;
    r    = $urandom;
    kind = r[3:0];
    rd   = r[8:4];
    rs1  = r[13:9];
    rs2  = r[18:14];
    f3   = r[21:19];
    f7   = r[22] ? F7_ALT : 7'b0;
    // second word for immediates
    r    = $urandom;
    rs1v = m_regs[rs1];
    rs2v = m_regs[rs2];
    next = m_pc + 32'd4;
    case (kind)
        4'd0: begin
            imm   = {r[31:12], 12'b0};
            instr = {r[31:12], rd, OP_LUI};
            write_reg(rd, imm);
        end
        4'd1: begin
            imm   = {r[31:12], 12'b0};
            instr = {r[31:12], rd, OP_AUIPC};
            write_reg(rd, m_pc + imm);
        end
        4'd2: begin
            imm   = {{11{r[20]}}, r[20:1], 1'b0};
            instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
            next  = m_pc + imm;
            write_reg(rd, m_pc + 32'd4);
        end
        4'd3: begin
            imm   = {{20{r[11]}}, r[11:0]};
            instr = {r[11:0], rs1, 3'b000, rd, OP_JALR};
            next  = (rs1v + imm) & ~32'd1;
            write_reg(rd, m_pc + 32'd4);
        end
        4'd4, 4'd5: begin
            if ((f3 == 3'b010) || (f3 == 3'b011)) begin
                f3 = {1'b1, f3[1:0]};
            end
            imm   = {{19{r[12]}}, r[12:1], 1'b0};
            instr = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
            if (branch_taken(f3, rs1v, rs2v)) begin
                next = m_pc + imm;
            end
        end
        4'd6, 4'd7, 4'd8: begin
            if (f3 == F3_SLL) begin
                imm = {27'b0, r[4:0]};
            end else if (f3 == F3_SR) begin
                imm = {20'b0, f7, r[4:0]};
            end else begin
                imm = {{20{r[11]}}, r[11:0]};
            end
            instr = {imm[11:0], rs1, f3, rd, OP_IMM};
            write_reg(rd, alu_op(f3, (f3 == F3_SR) && (f7 == F7_ALT), rs1v, imm));
        end
        4'd9, 4'd10, 4'd11: begin
            if ((f3 != F3_ADD) && (f3 != F3_SR)) begin
                f7 = 7'b0;
            end
            instr = {f7, rs2, rs1, f3, rd, OP_REG};
            write_reg(rd, alu_op(f3, f7 == F7_ALT, rs1v, rs2v));
        end
        4'd12, 4'd13, 4'd14: begin
            if ((f3 == 3'b011) || (f3[2:1] == 2'b11)) begin
                f3 = F3_LW;
            end
            imm          = {{20{r[11]}}, r[11:0]};
            instr        = {r[11:0], rs1, f3, rd, OP_LOAD};
            m_ld_pending = 1'b1;
            m_ld_addr    = rs1v + imm;
            m_ld_f3      = f3;
            m_ld_rd      = rd;
        end
        default: begin
            // unknown opcode, only the pc moves
            instr = r;
            while (is_known(instr[6:0])) begin
                instr[6:0] = instr[6:0] + 7'd1;
            end
        end
    endcase
    m_pc = next;
endtask

`endif

// File: bench/tb_core.sv
`default_nettype none

module tb_core
    import rv32_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          N_INSTR      = 2000;
    localparam int          RESET_CYCLES = 16;
    localparam int          MAX_CYCLES   = N_INSTR * 20 + RESET_CYCLES;
    localparam int unsigned SEED         = 32'h45c8_5ac4;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_ADDR,
        PH_DATA
    } bus_phase_e;

    logic    clk;
    logic    rst;
    wb_req_t bus_req;
    wb_rsp_t bus_rsp;
    int      cycles;

    rv32_core dut (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_bus_rsp (bus_rsp),
        .o_bus_req (bus_req)
    );

    `include "tb_model.svh"

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic fail_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic wb_req_t make_req(input logic cyc, input logic stb, input word_t addr);
        wb_req_t req;
        req.cyc  = cyc;
        req.stb  = stb;
        req.addr = addr;
        return req;
    endfunction

    task automatic check_addr(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected %08h, actual %08h", name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_req(input string name, input wb_req_t exp, input wb_req_t act);
        if (exp !== act) begin
            $display("mismatch %s: expected cyc=%b stb=%b addr=%08h, actual cyc=%b stb=%b addr=%08h",
                     name, exp.cyc, exp.stb, exp.addr, act.cyc, act.stb, act.addr);
            fail_run();
        end
    endtask

    // memory responder, checks at the falling edge and drives after the rising edge
    task automatic serve_bus();
        bus_phase_e phase;
        int         stall_left;
        int         ack_wait;
        int         n_fetch;
        logic       is_load;
        logic       done;
        word_t      cur_addr;
        word_t      rdata;
        phase      = PH_IDLE;
        stall_left = $urandom_range(0, 3);
        ack_wait   = 0;
        n_fetch    = 0;
        is_load    = 1'b0;
        done       = 1'b0;
        cur_addr   = '0;
        rdata      = '0;
        while (!done) begin
            @(negedge clk);
            if (phase == PH_IDLE) begin
                if (bus_req.stb) begin
                    is_load = m_ld_pending;
                    if (is_load) begin
                        check_addr($sformatf("load of instruction %0d", n_fetch),
                                   m_ld_addr, bus_req.addr);
                        cur_addr = m_ld_addr;
                        rdata    = mem_word(m_ld_addr);
                    end else begin
                        check_addr($sformatf("fetch %0d", n_fetch), m_pc, bus_req.addr);
                        cur_addr = m_pc;
                        if (n_fetch == N_INSTR) begin
                            done = 1'b1;
                        end else begin
                            next_instruction(rdata);
                            n_fetch++;
                        end
                    end
                    phase = PH_ADDR;
                end else begin
                    check_req("idle bus", make_req(1'b0, 1'b0, cur_addr), bus_req);
                end
            end
            if (done) begin
                break;
            end
            if (phase == PH_ADDR) begin
                check_req("request held", make_req(1'b1, 1'b1, cur_addr), bus_req);
                if (bus_rsp.stall) begin
                    stall_left--;
                end else begin
                    phase    = PH_DATA;
                    ack_wait = $urandom_range(0, 3);
                end
            end else if (phase == PH_DATA) begin
                check_req("waiting for ack", make_req(1'b1, 1'b0, cur_addr), bus_req);
                if (bus_rsp.ack) begin
                    if (is_load) begin
                        write_reg(m_ld_rd, load_result(m_ld_f3, m_ld_addr));
                        m_ld_pending = 1'b0;
                    end
                    phase      = PH_IDLE;
                    stall_left = $urandom_range(0, 3);
                end
            end
            @(posedge clk);
            #2;
            // stall raised ahead of the strobe
            bus_rsp.stall = (phase != PH_DATA) && (stall_left > 0);
            bus_rsp.ack   = 1'b0;
            bus_rsp.data  = '0;
            if (phase == PH_DATA) begin
                if (ack_wait == 0) begin
                    bus_rsp.ack  = 1'b1;
                    bus_rsp.data = rdata;
                end else begin
                    ack_wait--;
                end
            end
        end
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > MAX_CYCLES) begin
                $display("timeout: the core did not finish %0d instructions in %0d cycles",
                         N_INSTR, MAX_CYCLES);
                fail_run();
            end
        end
    end

    initial begin
        void'($urandom(SEED));
        rst     = 1'b1;
        bus_rsp = '0;
        clear_model();
        repeat (RESET_CYCLES - 1) begin
            @(negedge clk);
            check_req("reset", make_req(1'b0, 1'b0, '0), bus_req);
        end
        @(posedge clk);
        #2;
        rst = 1'b0;
        serve_bus();
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/core_control.sv
`default_nettype none

module core_control
    import rv32_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  logic      i_done,
    input  word_t     i_rdata,
    input  dec_t      i_dec,
    input  exec_res_t i_res,
    input  word_t     i_load_val,
    output instr_u    o_instr,
    output word_t     o_pc,
    output logic      o_start,
    output word_t     o_addr,
    output logic      o_we,
    output reg_addr_t o_wa,
    output word_t     o_wd
);

    stage_e stage;
    word_t  pc;
    instr_u ir;
    // a bus request is in flight
    logic   req_out;

    assign o_instr = ir;
    assign o_pc    = pc;

    // exec issues the load or the next fetch itself, fetch only after reset or a load
    always_comb begin
        o_start = 1'b0;
        o_addr  = pc;
        case (stage)
            STG_FETCH: begin
                o_start = !req_out;
            end
            STG_EXEC: begin
                o_start = 1'b1;
                o_addr  = i_dec.is_load ? i_res.mem_addr : i_res.next_pc;
            end
            default: begin
                o_start = 1'b0;
            end
        endcase
    end

    // write back
    assign o_we = (stage == STG_EXEC) ? i_res.wr_en : ((stage == STG_ACCESS) && i_done);
    assign o_wa = ir.r.rd;
    assign o_wd = (stage == STG_ACCESS) ? i_load_val : i_res.result;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            stage   <= STG_FETCH;
            pc      <= PC_START;
            req_out <= 1'b0;
        end else begin
            if (o_start) begin
                req_out <= 1'b1;
            end else if (i_done) begin
                req_out <= 1'b0;
            end
            case (stage)
                STG_FETCH: begin
                    if (i_done) begin
                        stage <= STG_DECODE;
                    end
                end
                STG_DECODE: begin
                    stage <= STG_EXEC;
                end
                STG_EXEC: begin
                    pc    <= i_res.next_pc;
                    stage <= i_dec.is_load ? STG_ACCESS : STG_FETCH;
                end
                STG_ACCESS: begin
                    if (i_done) begin
                        stage <= STG_FETCH;
                    end
                end
            endcase
        end
    end

    // instruction word taken in the ack cycle, held through access
    always_ff @(posedge i_clk) begin
        if ((stage == STG_FETCH) && i_done) begin
            ir <= i_rdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`default_nettype none

module exec_unit
    import rv32_pkg::*;
(
    input  dec_t      i_dec,
    input  word_t     i_pc,
    input  word_t     i_rs1,
    input  word_t     i_rs2,
    input  word_t     i_load_data,
    output exec_res_t o_res,
    output word_t     o_load_val
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      op_b;
    logic [4:0] shamt;
    word_t      alu;
    logic       take;
    word_t      pc_plus4;
    word_t      target;
    word_t      mem_addr;
    word_t      lane;
    logic [15:0] half;

    assign opcode   = i_dec.instr.r.opcode;
    assign funct3   = i_dec.instr.r.funct3;
    assign alt      = (i_dec.instr.r.funct7 == F7_ALT);
    assign op_b     = (opcode == OP_REG) ? i_rs2 : i_dec.imm;
    assign shamt    = op_b[4:0];
    assign pc_plus4 = i_pc + 32'd4;
    assign mem_addr = i_rs1 + i_dec.imm;
    assign target   = (opcode == OP_JALR) ? (mem_addr & ~32'd1) : (i_pc + i_dec.imm);

    always_comb begin
        alu = '0;
        case (funct3)
            F3_ADD:  alu = ((opcode == OP_REG) && alt) ? i_rs1 - op_b : i_rs1 + op_b;
            F3_SLL:  alu = i_rs1 << shamt;
            F3_SLT:  alu = {31'b0, $signed(i_rs1) < $signed(op_b)};
            F3_SLTU: alu = {31'b0, i_rs1 < op_b};
            F3_XOR:  alu = i_rs1 ^ op_b;
            F3_SR: begin
                if (alt) begin
                    alu = $signed(i_rs1) >>> shamt;
                end else begin
                    alu = i_rs1 >> shamt;
                end
            end
            F3_OR:   alu = i_rs1 | op_b;
            F3_AND:  alu = i_rs1 & op_b;
        endcase
    end

    always_comb begin
        case (funct3)
            F3_BEQ:  take = (i_rs1 == i_rs2);
            F3_BNE:  take = (i_rs1 != i_rs2);
            F3_BLT:  take = $signed(i_rs1) < $signed(i_rs2);
            F3_BGE:  take = $signed(i_rs1) >= $signed(i_rs2);
            F3_BLTU: take = i_rs1 < i_rs2;
            F3_BGEU: take = i_rs1 >= i_rs2;
            default: take = 1'b0;
        endcase
    end

    always_comb begin
        o_res.wr_en    = 1'b1;
        o_res.result   = alu;
        o_res.mem_addr = mem_addr;
        o_res.next_pc  = (i_dec.is_ctrl && ((opcode != OP_BRANCH) || take)) ? target : pc_plus4;
        case (opcode)
            OP_LUI:          o_res.result = i_dec.imm;
            OP_AUIPC:        o_res.result = i_pc + i_dec.imm;
            OP_JAL, OP_JALR: o_res.result = pc_plus4;
            OP_IMM, OP_REG:  o_res.result = alu;
            // loads write in access, branches and unknown opcodes never
            default:         o_res.wr_en = 1'b0;
        endcase
    end

    // byte lane by offset, halfword by bit 1
    assign lane = i_load_data >> {mem_addr[1:0], 3'b000};
    assign half = mem_addr[1] ? i_load_data[31:16] : i_load_data[15:0];

    always_comb begin
        case (funct3)
            F3_LB:   o_load_val = {{24{lane[7]}}, lane[7:0]};
            F3_LH:   o_load_val = {{16{half[15]}}, half};
            F3_LBU:  o_load_val = {24'b0, lane[7:0]};
            F3_LHU:  o_load_val = {16'b0, half};
            F3_LW:   o_load_val = i_load_data;
            default: o_load_val = i_load_data;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/instr_decode.sv
`default_nettype none

module instr_decode
    import rv32_pkg::*;
(
    input  instr_u i_instr,
    output dec_t   o_dec
);

    logic [6:0]  f7;
    reg_addr_t   rd;
    logic [19:0] up;

    assign f7 = i_instr.r.funct7;
    assign rd = i_instr.r.rd;
    assign up = i_instr.u.imm20;

    always_comb begin
        o_dec.instr   = i_instr;
        o_dec.is_load = (i_instr.r.opcode == OP_LOAD);
        o_dec.is_ctrl = (i_instr.r.opcode == OP_JAL) || (i_instr.r.opcode == OP_JALR) ||
                        (i_instr.r.opcode == OP_BRANCH);
        case (i_instr.r.opcode)
            OP_IMM, OP_JALR, OP_LOAD: begin
                o_dec.imm = {{20{f7[6]}}, f7, i_instr.r.rs2};
            end
            OP_BRANCH: begin
                o_dec.imm = {{20{f7[6]}}, rd[0], f7[5:0], rd[4:1], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                o_dec.imm = {up, 12'b0};
            end
            // J format reuses the upper field view
            OP_JAL: begin
                o_dec.imm = {{12{up[19]}}, up[7:0], up[8], up[18:9], 1'b0};
            end
            default: begin
                o_dec.imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

module reg_file
    import rv32_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst,
    input  reg_addr_t i_ra1,
    input  reg_addr_t i_ra2,
    output word_t     o_rd1,
    output word_t     o_rd2,
    input  logic      i_we,
    input  reg_addr_t i_wa,
    input  word_t     i_wd
);

    // x1 to x31, x0 has no storage
    word_t regs [1:NR_REGS-1];

    assign o_rd1 = (i_ra1 == '0) ? '0 : regs[i_ra1];
    assign o_rd2 = (i_ra2 == '0) ? '0 : regs[i_ra2];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < NR_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_wa != '0)) begin
            regs[i_wa] <= i_wd;
        end
    end

endmodule

`default_nettype wire

// File: hdl/rv32_core.sv
`default_nettype none

module rv32_core
    import rv32_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  wb_rsp_t i_bus_rsp,
    output wb_req_t o_bus_req
);

    instr_u    instr;
    dec_t      dec;
    exec_res_t res;
    word_t     pc;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     load_val;
    logic      bus_start;
    word_t     bus_addr;
    logic      bus_done;
    word_t     bus_rdata;
    logic      rf_we;
    reg_addr_t rf_wa;
    word_t     rf_wd;

    core_control u_control (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_done     (bus_done),
        .i_rdata    (bus_rdata),
        .i_dec      (dec),
        .i_res      (res),
        .i_load_val (load_val),
        .o_instr    (instr),
        .o_pc       (pc),
        .o_start    (bus_start),
        .o_addr     (bus_addr),
        .o_we       (rf_we),
        .o_wa       (rf_wa),
        .o_wd       (rf_wd)
    );

    instr_decode u_decode (
        .i_instr (instr),
        .o_dec   (dec)
    );

    reg_file u_regs (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_ra1 (instr.r.rs1),
        .i_ra2 (instr.r.rs2),
        .o_rd1 (rs1_val),
        .o_rd2 (rs2_val),
        .i_we  (rf_we),
        .i_wa  (rf_wa),
        .i_wd  (rf_wd)
    );

    // load data comes straight from the bus in the ack cycle
    exec_unit u_exec (
        .i_dec       (dec),
        .i_pc        (pc),
        .i_rs1       (rs1_val),
        .i_rs2       (rs2_val),
        .i_load_data (bus_rdata),
        .o_res       (res),
        .o_load_val  (load_val)
    );

    wb_master u_bus (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_start   (bus_start),
        .i_addr    (bus_addr),
        .o_done    (bus_done),
        .o_rdata   (bus_rdata),
        .i_bus_rsp (i_bus_rsp),
        .o_bus_req (o_bus_req)
    );

endmodule

`default_nettype wire

// File: hdl/rv32_pkg.sv
`default_nettype none

package rv32_pkg;

    localparam int XLEN    = 32;
    localparam int NR_REGS = 32;
    localparam int REG_AW  = 5;

    typedef logic [XLEN-1:0]   word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam word_t PC_START = 32'h2040_0000;

    // base opcodes
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // alu ops, shared by register and immediate forms
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    // selects SUB and SRA/SRAI
    localparam logic [6:0] F7_ALT = 7'b0100000;

    typedef enum logic [1:0] {
        STG_FETCH  = 2'd0,
        STG_DECODE = 2'd1,
        STG_EXEC   = 2'd2,
        STG_ACCESS = 2'd3
    } stage_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_addr_t  rs2;
        reg_addr_t  rs1;
        logic [2:0] funct3;
        reg_addr_t  rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_addr_t   rd;
        logic [6:0]  opcode;
    } instr_upper_t;

    typedef union packed {
        instr_r_t     r;
        instr_upper_t u;
    } instr_u;

    typedef struct packed {
        instr_u instr;
        word_t  imm;
        logic   is_load;
        logic   is_ctrl;
    } dec_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        word_t addr;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  stall;
        word_t data;
    } wb_rsp_t;

    typedef struct packed {
        logic  wr_en;
        word_t result;
        word_t next_pc;
        word_t mem_addr;
    } exec_res_t;

endpackage

`default_nettype wire

// File: hdl/wb_master.sv
`default_nettype none

module wb_master
    import rv32_pkg::*;
(
    input  logic    i_clk,
    input  logic    i_rst,
    input  logic    i_start,
    input  word_t   i_addr,
    output logic    o_done,
    output word_t   o_rdata,
    input  wb_rsp_t i_bus_rsp,
    output wb_req_t o_bus_req
);

    logic  cyc_q;
    logic  stb_q;
    word_t addr_q;

    assign o_bus_req = '{cyc: cyc_q, stb: stb_q, addr: addr_q};

    // one pulse, cyc drops right after the ack
    assign o_done  = cyc_q && i_bus_rsp.ack;
    assign o_rdata = i_bus_rsp.data;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cyc_q  <= 1'b0;
            stb_q  <= 1'b0;
            addr_q <= '0;
        end else begin
            // accepted once stall is low
            if (stb_q && !i_bus_rsp.stall) begin
                stb_q <= 1'b0;
            end
            if (o_done) begin
                cyc_q <= 1'b0;
                stb_q <= 1'b0;
            end
            if (i_start) begin
                cyc_q  <= 1'b1;
                stb_q  <= 1'b1;
                addr_q <= i_addr;
            end
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+bench
hdl/rv32_pkg.sv
hdl/instr_decode.sv
hdl/exec_unit.sv
hdl/reg_file.sv
hdl/wb_master.sv
hdl/core_control.sv
hdl/rv32_core.sv
bench/tb_core.sv
